//--- logic/sm83_isa_pkg.sv
package sm83_isa_pkg;

	typedef logic [7:0] opcode_t;  // One instruction byte.

	localparam opcode_t PREFIX_CB = 8'hcb;  // Selects the CB bank for the next byte.

	// ~~~~ CB opcode ~~~~~~~~~~
	typedef struct packed {
		logic [1:0] group;  // 0 for rotates and shifts.
		logic [2:0] kind;   // Which shift.
		logic [2:0] src;    // Register field.
	} cb_shift_t;

	typedef struct packed {
		logic [1:0] group;  // 1 BIT, 2 RES, 3 SET.
		logic [2:0] index;  // Bit number.
		logic [2:0] src;    // Register field.
	} cb_bit_t;

	typedef union packed {
		cb_shift_t shift;
		cb_bit_t   bits;
	} cb_opcode_u;

	typedef enum logic [2:0] {
		SK_RLC, SK_RRC, SK_RL, SK_RR, SK_SLA, SK_SRA, SK_SWAP, SK_SRL
	} shift_kind_t;  // Matches the kind field order.

	typedef enum logic [1:0] {CB_SHIFT, CB_BIT, CB_RES, CB_SET} cb_op_t;  // Same order as group.

	// ~~~~ Classes ~~~~~~~~~~~~
	typedef enum logic [3:0] {
		CLS_NONE, CLS_ALU8, CLS_INCDEC8, CLS_ROT_A, CLS_FLAGOP, CLS_ARITH16, CLS_LOAD8,
		CLS_LOAD16, CLS_STACK, CLS_JUMP, CLS_CALLRET, CLS_CONTROL, CLS_PREFIX, CLS_CB
	} instr_class_t;

endpackage

//--- logic/sm83_exec_pkg.sv
package sm83_exec_pkg;

	typedef struct packed {
		logic z;  // Zero.
		logic n;  // Subtract.
		logic h;  // Half carry.
		logic c;  // Carry.
	} flags_t;

	localparam int LANES      = 8;  // One lane per operand bit.
	localparam int PIPE_DEPTH = 3;  // Edges from byte to output.

endpackage

//--- logic/sm83_lane_if.sv
`timescale 1ns/10ps

interface sm83_lane_if;
	import sm83_isa_pkg::*;
	import sm83_exec_pkg::*;

	cb_op_t           op;          // Operation group.
	logic [2:0]       shift_kind;  // Rotate or shift selector.
	logic [2:0]       bit_sel;     // Target bit of BIT/RES/SET.
	logic [LANES-1:0] operand;     // Source byte.
	logic             carry_in;    // Old C for RL and RR.
	flags_t           flags_in;    // Flags before the operation.
	logic             valid;       // Issue register holds a byte.
	logic [LANES-1:0] res;         // One bit from each lane.

	modport issue (output op, shift_kind, bit_sel, operand, carry_in, flags_in, valid);
	modport lane  (input op, shift_kind, bit_sel, operand, carry_in, output res);
	modport drain (input op, shift_kind, bit_sel, operand, carry_in, flags_in, valid, res);
endinterface

//--- logic/sm83_prefix_seq.sv
`timescale 1ns/10ps

module sm83_prefix_seq (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  byte_valid,     // Byte strobe.
	input  sm83_isa_pkg::opcode_t byte_in,
	input  logic                  intr_entry_in,  // Interrupt entry level.
	output sm83_isa_pkg::opcode_t opcode,         // Registered byte.
	output logic                  bank_cb,        // Decode in the CB bank.
	output logic                  intr_entry,     // Byte came in during entry.
	output logic                  stage_valid     // Register holds a new byte.
);
	import sm83_isa_pkg::*;

	logic armed;  // Prefix seen and waiting for its byte.

	always_ff @(posedge clk) begin
		if (rst) begin
			armed       <= 1'b0;
			bank_cb     <= 1'b0;
			intr_entry  <= 1'b0;
			stage_valid <= 1'b0;
		end else begin
			stage_valid <= byte_valid;
			if (byte_valid) begin
				bank_cb    <= armed && !intr_entry_in;  // Entry cancels the prefix.
				intr_entry <= intr_entry_in;
				armed      <= !armed && !intr_entry_in && byte_in == PREFIX_CB;  // Main bank only.
			end
		end
	end

	always_ff @(posedge clk) begin
		if (byte_valid)
			opcode <= byte_in;
	end

endmodule

//--- logic/sm83_decode.sv
`timescale 1ns/10ps

module sm83_decode (
	input  sm83_isa_pkg::opcode_t opcode,  // Byte under decode.
	input  logic bank_cb,     // Byte follows a CB prefix.
	input  logic intr_entry,  // Interrupt entry blocks the main bank.
	input  logic in_alu,      // ALU group seen by the issue stage.
	output logic add_r,       // ALU op on r or (HL).
	output logic add_hl,      // ALU op on (HL).
	output logic add_n,       // ALU op on immediate.
	output logic add_x,       // ADD.
	output logic adc_x,       // ADC.
	output logic sub_x,       // SUB.
	output logic sbc_x,       // SBC.
	output logic and_x,       // AND.
	output logic xor_x,       // XOR.
	output logic or_x,        // OR.
	output logic cp_x,        // CP.
	output logic inc_m,       // INC or DEC on r or (HL).
	output logic inc_hl,      // INC or DEC on (HL).
	output logic dec_m,       // DEC on r or (HL).
	output logic rxxa,        // Accumulator rotates.
	output logic daa,         // Decimal adjust.
	output logic cpl,         // Complement A.
	output logic scf,         // Set carry.
	output logic ccf,         // Flip carry.
	output logic add_hl_ss,   // 16-bit add into HL.
	output logic add_sp_e,    // Signed add to SP.
	output logic inc_ss,      // 16-bit INC or DEC.
	output logic ld_r_r,      // Register moves. Also HALT.
	output logic ld_r_hl,     // Load r from (HL). Also HALT.
	output logic ld_hl_r,     // Store r to (HL). Also HALT.
	output logic ld_r_n,      // Immediate into r or (HL).
	output logic ld_hl_n,     // Immediate into (HL).
	output logic ld_xx_a,     // A through (BC) or (DE).
	output logic ld_hl_a,     // A through (HL+) or (HL-).
	output logic ld_x_dir,    // Store direction of the two above.
	output logic ldx_nn_a,    // A through (nn).
	output logic ld_n_a,      // A through high page (n).
	output logic ld_c_a,      // A through high page (C).
	output logic ld_n_dir,    // Store direction of high page moves. Also ADD SP.
	output logic ld_dd_nn,    // 16-bit immediate load.
	output logic ld_sp_hl,    // SP from HL.
	output logic ld_nn_sp,    // SP to (nn).
	output logic ldhl_sp_e,   // HL from SP plus offset.
	output logic push_pop,    // PUSH or POP.
	output logic push_qq,     // PUSH only.
	output logic jp_nn,       // Absolute jump.
	output logic jp_cc_nn,    // Conditional absolute jump.
	output logic jp_hl,       // Jump to HL.
	output logic jr_e,        // Relative jump.
	output logic jr_cc_e,     // Conditional relative jump.
	output logic call_nn,     // Call.
	output logic call_cc_nn,  // Conditional call.
	output logic ret,         // Return.
	output logic reti,        // Return and enable interrupts.
	output logic ret_cc,      // Conditional return.
	output logic rst_t,       // Restart vector.
	output logic nop,         // NOP.
	output logic stop,        // STOP.
	output logic halt,        // HALT.
	output logic di_ei,       // Interrupt enable change.
	output logic prefix_cb,   // Prefix byte.
	output logic rlc_m,       // CB rotates and shifts.
	output logic swap_m,      // CB SWAP.
	output logic bit_b_m,     // CB BIT.
	output logic res_b_m,     // CB RES.
	output logic set_b_m,     // CB SET.
	output logic cb_hl        // CB op on (HL).
);
	import sm83_isa_pkg::*;

	logic bank0;  // Main bank with no interrupt entry.

	assign bank0 = !bank_cb && !intr_entry;

	// ~~~~ ALU ops ~~~~~~~~~~~~
	assign add_x = in_alu && opcode[5:3] == 3'd0;
	assign adc_x = in_alu && opcode[5:3] == 3'd1;
	assign sub_x = in_alu && opcode[5:3] == 3'd2;
	assign sbc_x = in_alu && opcode[5:3] == 3'd3;
	assign and_x = in_alu && opcode[5:3] == 3'd4;
	assign xor_x = in_alu && opcode[5:3] == 3'd5;
	assign or_x  = in_alu && opcode[5:3] == 3'd6;
	assign cp_x  = in_alu && opcode[5:3] == 3'd7;

	// ~~~~ Arithmetic ~~~~~~~~~
	assign add_r     = bank0 && opcode[7:6] == 2'd2;                          // 80 to BF.
	assign add_hl    = bank0 && opcode[7:6] == 2'd2 && opcode[2:0] == 3'd6;  // Source field 6.
	assign add_n     = bank0 && opcode[7:6] == 2'd3 && opcode[2:0] == 3'd6;  // C6 to FE.
	assign inc_m     = bank0 && opcode[7:6] == 2'd0 && opcode[2:1] == 2'b10;  // Low bits 4 or 5.
	assign inc_hl    = bank0 && opcode inside {8'h34, 8'h35};
	assign dec_m     = bank0 && opcode[7:6] == 2'd0 && opcode[2:0] == 3'd5;
	assign rxxa      = bank0 && opcode[7:5] == 3'd0 && opcode[2:0] == 3'd7;  // 07 0F 17 1F.
	assign daa       = bank0 && opcode == 8'h27;
	assign cpl       = bank0 && opcode == 8'h2f;
	assign scf       = bank0 && opcode == 8'h37;
	assign ccf       = bank0 && opcode == 8'h3f;
	assign add_hl_ss = bank0 && opcode[7:6] == 2'd0 && opcode[3:0] == 4'h9;
	assign add_sp_e  = bank0 && opcode == 8'he8;
	assign inc_ss    = bank0 && opcode[7:6] == 2'd0 && opcode[2:0] == 3'd3;  // x3 and xB.

	// ~~~~ Loads ~~~~~~~~~~~~~~
	assign ld_r_r    = bank0 && opcode[7:6] == 2'd1;                          // 76 lands here too.
	assign ld_r_hl   = bank0 && opcode[7:6] == 2'd1 && opcode[2:0] == 3'd6;
	assign ld_hl_r   = bank0 && opcode[7:3] == 5'b01110;                      // 70 to 77.
	assign ld_r_n    = bank0 && opcode[7:6] == 2'd0 && opcode[2:0] == 3'd6;
	assign ld_hl_n   = bank0 && opcode == 8'h36;
	assign ld_xx_a   = bank0 && opcode[7:5] == 3'd0 && opcode[2:0] == 3'd2;  // 02 0A 12 1A.
	assign ld_hl_a   = bank0 && opcode[7:5] == 3'd1 && opcode[2:0] == 3'd2;  // 22 2A 32 3A.
	assign ld_x_dir  = bank0 && opcode[7:6] == 2'd0 && opcode[3:0] == 4'h2;  // Stores only.
	assign ldx_nn_a  = bank0 && opcode inside {8'hea, 8'hfa};
	assign ld_n_a    = bank0 && opcode inside {8'he0, 8'hf0};
	assign ld_c_a    = bank0 && opcode inside {8'he2, 8'hf2};
	assign ld_n_dir  = bank0 && opcode inside {8'he0, 8'he2, 8'he8, 8'hea};
	assign ld_dd_nn  = bank0 && opcode[7:6] == 2'd0 && opcode[3:0] == 4'h1;
	assign ld_sp_hl  = bank0 && opcode == 8'hf9;
	assign ld_nn_sp  = bank0 && opcode == 8'h08;
	assign ldhl_sp_e = bank0 && opcode == 8'hf8;
	assign push_pop  = bank0 && opcode[7:6] == 2'd3 && opcode[3:0] inside {4'h1, 4'h5};
	assign push_qq   = bank0 && opcode[7:6] == 2'd3 && opcode[3:0] == 4'h5;

	// ~~~~ Control flow ~~~~~~~
	assign jp_nn      = bank0 && opcode == 8'hc3;
	assign jp_cc_nn   = bank0 && opcode[7:5] == 3'd6 && opcode[2:0] == 3'd2;  // C2 CA D2 DA.
	assign jp_hl      = bank0 && opcode == 8'he9;
	assign jr_e       = bank0 && opcode == 8'h18;
	assign jr_cc_e    = bank0 && opcode[7:5] == 3'd1 && opcode[2:0] == 3'd0;  // 20 28 30 38.
	assign call_nn    = bank0 && opcode == 8'hcd;
	assign call_cc_nn = bank0 && opcode[7:5] == 3'd6 && opcode[2:0] == 3'd4;
	assign ret        = bank0 && opcode == 8'hc9;
	assign reti       = bank0 && opcode == 8'hd9;
	assign ret_cc     = bank0 && opcode[7:5] == 3'd6 && opcode[2:0] == 3'd0;
	assign rst_t      = bank0 && opcode[7:6] == 2'd3 && opcode[2:0] == 3'd7;  // Eight vectors.

	assign nop       = bank0 && opcode == 8'h00;
	assign stop      = bank0 && opcode == 8'h10;
	assign halt      = bank0 && opcode == 8'h76;
	assign di_ei     = bank0 && opcode inside {8'hf3, 8'hfb};
	assign prefix_cb = bank0 && opcode == PREFIX_CB;

	// CB bank keys on the group field.
	assign rlc_m   = bank_cb && opcode[7:6] == 2'd0;
	assign swap_m  = bank_cb && opcode[7:3] == 5'd6;
	assign bit_b_m = bank_cb && opcode[7:6] == 2'd1;
	assign res_b_m = bank_cb && opcode[7:6] == 2'd2;
	assign set_b_m = bank_cb && opcode[7:6] == 2'd3;
	assign cb_hl   = bank_cb && opcode[2:0] == 3'd6;  // Memory operand form.

endmodule

//--- logic/sm83_cb_issue.sv
`timescale 1ns/10ps

module sm83_cb_issue (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   stage_valid,  // Decoder input is a new byte.
	input  sm83_isa_pkg::opcode_t  opcode,
	input  logic [7:0]             operand_in,
	input  sm83_exec_pkg::flags_t  flags_in,
	input  logic add_r, add_n, inc_m, rxxa, daa, cpl, scf, ccf,
	input  logic add_hl_ss, add_sp_e, inc_ss,
	input  logic ld_r_r, ld_r_n, ld_xx_a, ld_hl_a, ldx_nn_a, ld_n_a, ld_c_a,
	input  logic ld_dd_nn, ld_sp_hl, ld_nn_sp, ldhl_sp_e, push_pop,
	input  logic jp_nn, jp_cc_nn, jp_hl, jr_e, jr_cc_e,
	input  logic call_nn, call_cc_nn, ret, reti, ret_cc, rst_t,
	input  logic nop, stop, halt, di_ei, prefix_cb,
	input  logic rlc_m, bit_b_m, res_b_m, set_b_m,
	output logic                   in_alu,  // ALU group back to the decoder.
	output sm83_isa_pkg::instr_class_t cls,  // Registered class.
	sm83_lane_if.issue             ctl
);
	import sm83_isa_pkg::*;

	cb_opcode_u   cb;        // Two views of the same byte.
	instr_class_t cls_next;

	assign in_alu = add_r || add_n;
	assign cb     = opcode;

	always_comb begin
		if (nop || stop || halt || di_ei)                        cls_next = CLS_CONTROL;  // Before loads.
		else if (rlc_m || bit_b_m || res_b_m || set_b_m)         cls_next = CLS_CB;
		else if (prefix_cb)                                      cls_next = CLS_PREFIX;
		else if (in_alu)                                         cls_next = CLS_ALU8;
		else if (inc_m)                                          cls_next = CLS_INCDEC8;
		else if (rxxa)                                           cls_next = CLS_ROT_A;
		else if (daa || cpl || scf || ccf)                       cls_next = CLS_FLAGOP;
		else if (add_hl_ss || add_sp_e || inc_ss)                cls_next = CLS_ARITH16;
		else if (ld_r_r || ld_r_n || ld_xx_a || ld_hl_a || ldx_nn_a || ld_n_a || ld_c_a)
			cls_next = CLS_LOAD8;
		else if (ld_dd_nn || ld_sp_hl || ld_nn_sp || ldhl_sp_e)  cls_next = CLS_LOAD16;
		else if (push_pop)                                       cls_next = CLS_STACK;
		else if (jp_nn || jp_cc_nn || jp_hl || jr_e || jr_cc_e)  cls_next = CLS_JUMP;
		else if (call_nn || call_cc_nn || ret || reti || ret_cc || rst_t)
			cls_next = CLS_CALLRET;
		else                                                     cls_next = CLS_NONE;  // Unused slots.
	end

	always_ff @(posedge clk) begin
		if (rst)
			ctl.valid <= 1'b0;
		else
			ctl.valid <= stage_valid;
	end

	always_ff @(posedge clk) begin
		if (stage_valid) begin
			cls          <= cls_next;
			ctl.operand  <= operand_in;
			ctl.flags_in <= flags_in;
			ctl.carry_in <= flags_in.c;  // Feeds RL and RR.
			if (cb.shift.group == 2'd0) begin
				ctl.op         <= CB_SHIFT;
				ctl.shift_kind <= cb.shift.kind;
			end else begin
				ctl.op      <= cb_op_t'(cb.bits.group);  // Group order equals cb_op_t.
				ctl.bit_sel <= cb.bits.index;
			end
		end
	end

endmodule

//--- logic/sm83_cb_lane.sv
`timescale 1ns/10ps

module sm83_cb_lane #(
	parameter int POS = 0  // Bit position served.
) (
	sm83_lane_if.lane ctl
);
	import sm83_isa_pkg::*;
	import sm83_exec_pkg::*;

	localparam int LO = (POS + LANES - 1) % LANES;  // Lower neighbour. Bit 0 wraps to 7.
	localparam int HI = (POS + 1) % LANES;          // Upper neighbour. Bit 7 wraps to 0.
	localparam int SW = POS ^ (LANES / 2);          // Other nibble.

	logic own, hit, from_lo, from_hi, shifted, bit_out;

	assign own = ctl.operand[POS];
	assign hit = ctl.bit_sel == 3'(POS);

	always_comb begin
		from_lo = ctl.operand[LO];  // RLC gets its wrap for free.
		from_hi = ctl.operand[HI];  // So does RRC.
		if (POS == 0 && ctl.shift_kind == SK_RL)          from_lo = ctl.carry_in;
		if (POS == 0 && ctl.shift_kind == SK_SLA)         from_lo = 1'b0;
		if (POS == LANES - 1 && ctl.shift_kind == SK_RR)  from_hi = ctl.carry_in;
		if (POS == LANES - 1 && ctl.shift_kind == SK_SRA) from_hi = own;  // Sign kept.
		if (POS == LANES - 1 && ctl.shift_kind == SK_SRL) from_hi = 1'b0;
		if (ctl.shift_kind == SK_SWAP)
			shifted = ctl.operand[SW];
		else
			shifted = ctl.shift_kind[0] ? from_hi : from_lo;  // Odd kinds go right.
		case (ctl.op)
			CB_SHIFT: bit_out = shifted;
			CB_RES:   bit_out = hit ? 1'b0 : own;
			CB_SET:   bit_out = hit ? 1'b1 : own;
			default:  bit_out = own;  // BIT only reads.
		endcase
	end

	assign ctl.res[POS] = bit_out;

endmodule

//--- logic/sm83_cb_flags.sv
`timescale 1ns/10ps

module sm83_cb_flags (
	input  logic                       clk,
	input  logic                       rst,
	input  sm83_isa_pkg::instr_class_t cls_in,
	input  logic                       pipe_valid,  // Issue register holds a byte.
	sm83_lane_if.drain                 res_bus,
	output logic                       out_valid,
	output sm83_isa_pkg::instr_class_t out_class,
	output logic                       cb_valid,
	output logic [7:0]                 result,
	output sm83_exec_pkg::flags_t      flags_out
);
	import sm83_isa_pkg::*;
	import sm83_exec_pkg::*;

	logic   is_cb;
	logic   shift_out;   // Bit pushed out by a rotate or shift.
	flags_t flags_next;

	assign is_cb = cls_in == CLS_CB;

	always_comb begin
		case (res_bus.shift_kind)
			SK_RLC, SK_RL, SK_SLA: shift_out = res_bus.operand[7];
			SK_SWAP:               shift_out = 1'b0;
			default:               shift_out = res_bus.operand[0];
		endcase
		flags_next = res_bus.flags_in;  // RES, SET and main bank.
		if (is_cb && res_bus.op == CB_SHIFT) begin
			flags_next.z = res_bus.res == '0;
			flags_next.n = 1'b0;
			flags_next.h = 1'b0;
			flags_next.c = shift_out;
		end else if (is_cb && res_bus.op == CB_BIT) begin
			flags_next.z = !res_bus.operand[res_bus.bit_sel];
			flags_next.n = 1'b0;
			flags_next.h = 1'b1;  // C passes through.
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
			cb_valid  <= 1'b0;
			out_class <= CLS_NONE;
		end else begin
			out_valid <= pipe_valid;
			cb_valid  <= pipe_valid && is_cb;
			if (pipe_valid)
				out_class <= cls_in;
		end
	end

	always_ff @(posedge clk) begin
		if (pipe_valid) begin
			result    <= is_cb ? res_bus.res : res_bus.operand;  // Main bank echoes the operand.
			flags_out <= flags_next;
		end
	end

endmodule

//--- logic/sm83_cb_exec.sv
`timescale 1ns/10ps

module sm83_cb_exec (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       byte_valid,
	input  sm83_isa_pkg::opcode_t      byte_in,
	input  logic                       intr_entry,
	input  logic [7:0]                 operand,
	input  sm83_exec_pkg::flags_t      flags_in,
	output logic                       out_valid,
	output sm83_isa_pkg::instr_class_t out_class,
	output logic                       cb_valid,
	output logic [7:0]                 result,
	output sm83_exec_pkg::flags_t      flags_out
);
	import sm83_isa_pkg::*;
	import sm83_exec_pkg::*;

	opcode_t      opcode;
	logic         bank_cb, intr_q, stage_valid, in_alu;
	logic [7:0]   operand_q;  // Operand aligned with the registered byte.
	flags_t       flags_q;
	instr_class_t cls;

	// ~~~~ Decoder flags ~~~~~~
	logic add_r, add_n, inc_m, rxxa, daa, cpl, scf, ccf;
	logic add_hl_ss, add_sp_e, inc_ss;
	logic ld_r_r, ld_r_n, ld_xx_a, ld_hl_a, ldx_nn_a, ld_n_a, ld_c_a;
	logic ld_dd_nn, ld_sp_hl, ld_nn_sp, ldhl_sp_e, push_pop;
	logic jp_nn, jp_cc_nn, jp_hl, jr_e, jr_cc_e;
	logic call_nn, call_cc_nn, ret, reti, ret_cc, rst_t;
	logic nop, stop, halt, di_ei, prefix_cb;
	logic rlc_m, bit_b_m, res_b_m, set_b_m;

	sm83_lane_if lane_bus ();

	always_ff @(posedge clk) begin
		if (byte_valid) begin
			operand_q <= operand;  // Same edge as the byte.
			flags_q   <= flags_in;
		end
	end

	sm83_prefix_seq u_seq (
		.clk(clk), .rst(rst),
		.byte_valid(byte_valid), .byte_in(byte_in), .intr_entry_in(intr_entry),
		.opcode(opcode), .bank_cb(bank_cb), .intr_entry(intr_q), .stage_valid(stage_valid)
	);

	sm83_decode u_decode (
		.*,
		.intr_entry(intr_q),
		.add_hl(), .add_x(), .adc_x(), .sub_x(), .sbc_x(), .and_x(), .xor_x(), .or_x(),
		.cp_x(), .inc_hl(), .dec_m(), .ld_r_hl(), .ld_hl_r(), .ld_hl_n(), .ld_x_dir(),
		.ld_n_dir(), .push_qq(), .swap_m(), .cb_hl()
	);

	sm83_cb_issue u_issue (.*, .operand_in(operand_q), .flags_in(flags_q), .ctl(lane_bus));

	for (genvar i = 0; i < LANES; i++) begin : g_lane
		sm83_cb_lane #(.POS(i)) u_lane (.ctl(lane_bus));
	end

	sm83_cb_flags u_flags (.*, .cls_in(cls), .pipe_valid(lane_bus.valid), .res_bus(lane_bus));

endmodule

//--- verif/sm83_cb_exec_assertions.sv
`timescale 1ns/10ps

module sm83_cb_exec_assertions (
	input logic clk,
	input logic rst,
	input logic byte_valid,
	input logic out_valid,
	input logic cb_valid
);
	import sm83_exec_pkg::*;

	// ~~~~ Output strobes ~~~~
	a_latency: assert property (@(posedge clk) disable iff (rst)
		out_valid == $past(byte_valid, PIPE_DEPTH))  // One output per byte, fixed delay.
		else $error("out_valid does not follow byte_valid by %0d edges", PIPE_DEPTH);

	a_cb_in_out: assert property (@(posedge clk) disable iff (rst) cb_valid |-> out_valid)
		else $error("cb_valid is high while out_valid is low");

	a_reset: assert property (@(posedge clk) rst |=> !out_valid && !cb_valid)  // Cleared by reset.
		else $error("out_valid or cb_valid is high during reset");

endmodule

bind sm83_cb_exec sm83_cb_exec_assertions assertions_inst (
	.clk(clk), .rst(rst), .byte_valid(byte_valid), .out_valid(out_valid), .cb_valid(cb_valid)
);

//--- verif/sm83_cb_exec_checker.sv
`timescale 1ns/10ps

module sm83_cb_exec_checker (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       byte_valid,   // Byte offered to the DUT.
	input  sm83_isa_pkg::instr_class_t exp_class,    // Expected values travel with the byte.
	input  logic [7:0]                 exp_result,
	input  sm83_exec_pkg::flags_t      exp_flags,
	input  logic                       out_valid,
	input  sm83_isa_pkg::instr_class_t out_class,
	input  logic                       cb_valid,
	input  logic [7:0]                 result,
	input  sm83_exec_pkg::flags_t      flags_out,
	output int                         mismatches,
	output int                         timeouts,
	output int                         pending      // Bytes still waiting for output.
);
	import sm83_isa_pkg::*;
	import sm83_exec_pkg::*;

	typedef struct packed {
		instr_class_t cls;
		logic [7:0]   result;  // Only meaningful for CB bytes.
		flags_t       flags;
	} entry_t;

	localparam int WAIT_LIMIT = PIPE_DEPTH + 2;  // Falling edges an entry may wait.

	entry_t exp_q[$];
	entry_t head;
	int     waited;
	logic   exp_cb;

	// Falling edge sits halfway between DUT updates and stimulus changes.
	always @(negedge clk) begin
		if (rst) begin
			exp_q.delete();
			mismatches = 0;
			timeouts   = 0;
			waited     = 0;
		end else begin
			if (out_valid && exp_q.size() == 0) begin
				$display("MISMATCH at %0t: output with no byte pending", $time);
				mismatches++;
			end else if (out_valid) begin
				head   = exp_q.pop_front();  // Outputs come back in byte order.
				exp_cb = head.cls == CLS_CB;
				if (out_class !== head.cls || cb_valid !== exp_cb || flags_out !== head.flags
						|| (exp_cb && result !== head.result)) begin
					$write("MISMATCH at %0t: class %0d exp %0d, cb_valid %b exp %b,", $time,
						out_class, head.cls, cb_valid, exp_cb);
					$display(" result %h exp %h, flags %b exp %b", result, head.result,
						flags_out, head.flags);
					mismatches++;
				end
			end
			if (byte_valid)
				exp_q.push_back(entry_t'({exp_class, exp_result, exp_flags}));
			waited = (exp_q.size() != 0 && !out_valid) ? waited + 1 : 0;
			if (waited > WAIT_LIMIT) begin
				$display("Timeout at %0t: output for a pending byte did not arrive", $time);
				timeouts++;
				head   = exp_q.pop_front();  // Drop it so later bytes stay aligned.
				waited = 0;
			end
		end
		pending = exp_q.size();
	end

endmodule

//--- verif/sm83_cb_exec_tb.sv
`timescale 1ns/10ps

module sm83_cb_exec_tb;
	import sm83_isa_pkg::*;
	import sm83_exec_pkg::*;

	typedef struct packed {
		opcode_t      op;
		logic         intr;       // Interrupt entry level with the byte.
		logic [7:0]   operand;
		flags_t       flags;
		instr_class_t cls;        // Expected class.
		logic [7:0]   result;     // Compared on CB rows only.
		flags_t       exp_flags;
		logic [1:0]   idle;       // Empty cycles ahead of the byte.
	} row_t;

	logic         clk, rst, byte_valid, intr_entry;
	opcode_t      byte_in;
	logic [7:0]   operand, result, exp_result;
	flags_t       flags_in, flags_out, exp_flags;
	instr_class_t out_class, exp_class;
	logic         out_valid, cb_valid;
	int           mismatches, timeouts, pending;
	row_t         rows[$];

	always #10 clk = ~clk;  // 20 ns period.

	function automatic logic [31:0] xorshift32(logic [31:0] s);
		logic [31:0] v;
		v = s ^ (s << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	// ~~~~ Reference rules ~~~~
	function automatic row_t cb_row(opcode_t op, logic [7:0] x, flags_t f, int idle);
		row_t       r;
		logic [2:0] b;
		b = op[5:3];  // Shift kind or bit index.
		r = row_t'({op, 1'b0, x, f, CLS_CB, x, f, 2'(idle)});
		case (op[7:6])
			2'd0: begin
				case (b)
					3'd0: {r.exp_flags.c, r.result} = {x[7], x[6:0], x[7]};  // RLC.
					3'd1: {r.exp_flags.c, r.result} = {x[0], x[0], x[7:1]};  // RRC.
					3'd2: {r.exp_flags.c, r.result} = {x[7], x[6:0], f.c};   // RL.
					3'd3: {r.exp_flags.c, r.result} = {x[0], f.c, x[7:1]};   // RR.
					3'd4: {r.exp_flags.c, r.result} = {x[7], x[6:0], 1'b0};  // SLA.
					3'd5: {r.exp_flags.c, r.result} = {x[0], x[7], x[7:1]};  // SRA.
					3'd6: {r.exp_flags.c, r.result} = {1'b0, x[3:0], x[7:4]};
					default: {r.exp_flags.c, r.result} = {x[0], 1'b0, x[7:1]};
				endcase
				r.exp_flags.z = r.result == 8'h00;
				r.exp_flags.n = 1'b0;
				r.exp_flags.h = 1'b0;
			end
			2'd1: r.exp_flags = {!x[b], 1'b0, 1'b1, f.c};  // BIT leaves the byte alone.
			2'd2: r.result = x & ~(8'h01 << b);
			default: r.result = x | (8'h01 << b);
		endcase
		return r;
	endfunction

	task automatic add_main(opcode_t op, logic intr, instr_class_t cls);
		flags_t f;
		f = flags_t'(op[3:0] ^ 4'h5);
		rows.push_back(row_t'({op, intr, ~op, f, cls, ~op, f, 2'd0}));  // Flags pass through.
	endtask

	task automatic add_cb(opcode_t op, logic [7:0] x, logic [3:0] f, int idle);
		add_main(PREFIX_CB, 1'b0, CLS_PREFIX);
		rows.push_back(cb_row(op, x, flags_t'(f), idle));  // Idle splits the prefix.
	endtask

	sm83_cb_exec sm83_cb_exec_inst (.*);

	sm83_cb_exec_checker check_inst (.*);

	initial begin
		logic [31:0] seed;
		clk        = 1'b0;
		rst        = 1'b1;
		byte_valid = 1'b0;
		intr_entry = 1'b0;
		byte_in    = 8'h00;
		operand    = 8'h00;
		flags_in   = '0;
		exp_class  = CLS_NONE;
		exp_result = 8'h00;
		exp_flags  = '0;
		seed       = 32'h91ea23f4;
		// ~~~~ Stimulus table ~~~~
		add_main(8'h80, 1'b0, CLS_ALU8);
		add_main(8'h76, 1'b0, CLS_CONTROL);  // HALT wins over the load group.
		add_main(8'h3d, 1'b0, CLS_INCDEC8);
		add_main(8'hc9, 1'b0, CLS_CALLRET);
		add_main(8'h36, 1'b0, CLS_LOAD8);
		for (int k = 0; k < 8; k++)
			add_cb({2'd0, 3'(k), 3'd7}, 8'(150 + 41 * k), 4'(k), k % 3);  // Every shift kind.
		add_cb(8'h38, 8'h01, 4'hf, 0);  // SRL down to zero.
		add_cb(8'h00, 8'h00, 4'h0, 0);  // RLC of zero.
		add_cb(8'h2f, 8'h81, 4'h0, 0);  // SRA keeps a set sign bit.
		add_cb(8'h17, 8'h80, 4'h1, 1);  // RL pulls the old carry in.
		add_cb(8'h7c, 8'h80, 4'h9, 0);  // BIT 7,H on a set bit.
		add_cb(8'h47, 8'hfe, 4'h4, 2);
		add_cb(8'hb8, 8'hff, 4'ha, 1);  // RES 7,B.
		add_cb(8'hd6, 8'h00, 4'h5, 0);  // SET 2,(HL) takes the operand port.
		add_main(PREFIX_CB, 1'b0, CLS_PREFIX);
		add_main(8'h00, 1'b1, CLS_NONE);  // Entry drops the pending prefix.
		add_main(8'h37, 1'b0, CLS_FLAGOP);
		for (int k = 0; k < 16; k++) begin
			seed = xorshift32(seed);
			add_cb(seed[7:0], seed[15:8], seed[19:16], int'(seed[21:20]));
		end
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
		for (int i = 0; i < rows.size(); i++) begin
			repeat (rows[i].idle) begin
				byte_valid = 1'b0;
				@(posedge clk);
				#1;
			end
			byte_valid = 1'b1;
			byte_in    = rows[i].op;
			intr_entry = rows[i].intr;
			operand    = rows[i].operand;
			flags_in   = rows[i].flags;
			exp_class  = rows[i].cls;
			exp_result = rows[i].result;
			exp_flags  = rows[i].exp_flags;
			@(posedge clk);
			#1;
		end
		byte_valid = 1'b0;
		intr_entry = 1'b0;
		for (int n = 0; n < 4 * PIPE_DEPTH && pending != 0; n++)
			@(posedge clk);
		if (pending != 0)
			$display("Outputs never arrived for %0d bytes at the end of the stream", pending);
		$display("Errors: %0d mismatches, %0d timeouts, %0d missing", mismatches, timeouts, pending);
		if (mismatches == 0 && timeouts == 0 && pending == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		#100000;
		$display("Run stopped by the simulation time limit before the stream finished");
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- sm83_cb_exec.f
logic/sm83_isa_pkg.sv
logic/sm83_exec_pkg.sv
logic/sm83_lane_if.sv
logic/sm83_prefix_seq.sv
logic/sm83_decode.sv
logic/sm83_cb_issue.sv
logic/sm83_cb_lane.sv
logic/sm83_cb_flags.sv
logic/sm83_cb_exec.sv
verif/sm83_cb_exec_assertions.sv
verif/sm83_cb_exec_checker.sv
verif/sm83_cb_exec_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the SM83 CB slice testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module sm83_cb_exec_tb \
	-f sm83_cb_exec.f -o sm83_cb_exec_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sm83_cb_exec_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "ALL CHECKS PASSED"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1
